// ==== include/rv64_cfg.svh ====
`ifndef RV64_CFG_SVH
`define RV64_CFG_SVH

// machine width and reset vector
`define XLEN      64
`define RESET_PC  64'h0000_0000_0000_0000

// major opcodes
`define OPC_OP         7'b0110011
`define OPC_OP_IMM     7'b0010011
`define OPC_OP_32      7'b0111011
`define OPC_OP_IMM_32  7'b0011011
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_BRANCH     7'b1100011
`define OPC_STORE      7'b0100011
`define OPC_SYSTEM     7'b1110011

// funct3 for the integer ops
`define F3_ADD   3'b000
`define F3_SLL   3'b001
`define F3_SLT   3'b010
`define F3_SLTU  3'b011
`define F3_XOR   3'b100
`define F3_SRL   3'b101
`define F3_OR    3'b110
`define F3_AND   3'b111

// funct3 for jalr and the branches
`define F3_JALR  3'b000
`define F3_BEQ   3'b000
`define F3_BNE   3'b001
`define F3_BLT   3'b100
`define F3_BGE   3'b101
`define F3_BLTU  3'b110
`define F3_BGEU  3'b111

// funct7
`define F7_BASE  7'b0000000
`define F7_ALT   7'b0100000

`define INST_EBREAK  32'h0010_0073

`endif

// ==== src/rv64_pkg.sv ====
`include "rv64_cfg.svh"

package rv64_pkg;

  // ====================
  // data and address types
  // ====================

  // one machine word
  typedef logic [`XLEN-1:0] xlen_t;

  // raw instruction as fetched
  typedef logic [31:0] inst_t;

  // index into the integer register file
  typedef logic [4:0] reg_addr_t;

  // ====================
  // alu selection
  // ====================

  // word forms reuse ALU_ADD and ALU_SUB with a separate word flag
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLT  = 4'd2,
    ALU_SLTU = 4'd3,
    ALU_AND  = 4'd4,
    ALU_OR   = 4'd5,
    ALU_XOR  = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_e;

endpackage

// ==== src/key_mux.sv ====
module key_mux #(
  parameter int NR_KEY = 2
) (
  input  logic [NR_KEY-1:0]               key_i,
  input  rv64_pkg::xlen_t                 default_i,
  input  rv64_pkg::xlen_t [NR_KEY-1:0]    data_i,
  output rv64_pkg::xlen_t                 out_o
);

  // key bit k picks data_i[k]
  // keys are one-hot so the scan order does not matter
  always_comb begin
    out_o = default_i;
    for (int k = 0; k < NR_KEY; k++) begin
      if (key_i[k]) begin
        out_o = data_i[k];
      end
    end
  end

endmodule

// ==== src/inst_decode.sv ====
`include "rv64_cfg.svh"

module inst_decode (
  input  rv64_pkg::xlen_t     pc_i,
  input  rv64_pkg::inst_t     inst_i,
  input  rv64_pkg::xlen_t     rdata1_i,
  input  rv64_pkg::xlen_t     rdata2_i,
  output rv64_pkg::reg_addr_t raddr1_o,
  output rv64_pkg::reg_addr_t raddr2_o,
  output logic                rd_we_o,
  output rv64_pkg::reg_addr_t rd_addr_o,
  output rv64_pkg::xlen_t     op1_o,
  output rv64_pkg::xlen_t     op2_o,
  output rv64_pkg::alu_op_e   alu_op_o,
  output logic                alu_word_o,
  output logic                taken_o,
  output rv64_pkg::xlen_t     target_o,
  output logic                halt_o
);
  import rv64_pkg::*;

  // instruction fields
  wire [6:0] opcode = inst_i[6:0];
  wire [2:0] funct3 = inst_i[14:12];
  wire [6:0] funct7 = inst_i[31:25];

  // ====================
  // immediates
  // ====================
  wire xlen_t imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  wire xlen_t imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  wire xlen_t imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
  wire xlen_t imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  wire xlen_t imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                       inst_i[30:21], 1'b0};

  // ====================
  // opcode classes
  // ====================
  wire opc_r      = (opcode == `OPC_OP);
  wire opc_i      = (opcode == `OPC_OP_IMM);
  wire opc_w      = (opcode == `OPC_OP_32);
  wire opc_iw     = (opcode == `OPC_OP_IMM_32);
  wire opc_lui    = (opcode == `OPC_LUI);
  wire opc_auipc  = (opcode == `OPC_AUIPC);
  wire opc_jal    = (opcode == `OPC_JAL);
  wire opc_jalr   = (opcode == `OPC_JALR);
  wire opc_branch = (opcode == `OPC_BRANCH);
  // stores are not executed, only their immediate is formed
  wire opc_store  = (opcode == `OPC_STORE);

  wire f7_base = (funct7 == `F7_BASE);
  wire f7_alt  = (funct7 == `F7_ALT);
  wire f3_alt_ok = (funct3 == `F3_ADD) || (funct3 == `F3_SRL);
  wire f3_shift  = (funct3 == `F3_SLL) || (funct3 == `F3_SRL);
  // shamt[5] is part of the immediate on rv64
  wire shamt_ok  = (inst_i[31:26] == 6'b000000) ||
                   ((funct3 == `F3_SRL) && (inst_i[31:26] == 6'b010000));

  wire valid_r    = opc_r && (f7_base || (f7_alt && f3_alt_ok));
  wire valid_i    = opc_i && (!f3_shift || shamt_ok);
  wire valid_w    = opc_w && (funct3 == `F3_ADD) && (f7_base || f7_alt);
  wire valid_iw   = opc_iw && (funct3 == `F3_ADD);
  wire valid_jalr = opc_jalr && (funct3 == `F3_JALR);
  wire is_ebreak  = (inst_i == `INST_EBREAK);

  // ====================
  // alu control
  // ====================
  always_comb begin
    alu_op_o = ALU_ADD;
    if (valid_r || valid_i) begin
      case (funct3)
        `F3_ADD:  alu_op_o = (valid_r && inst_i[30]) ? ALU_SUB : ALU_ADD;
        `F3_SLL:  alu_op_o = ALU_SLL;
        `F3_SLT:  alu_op_o = ALU_SLT;
        `F3_SLTU: alu_op_o = ALU_SLTU;
        `F3_XOR:  alu_op_o = ALU_XOR;
        `F3_SRL:  alu_op_o = inst_i[30] ? ALU_SRA : ALU_SRL;
        `F3_OR:   alu_op_o = ALU_OR;
        `F3_AND:  alu_op_o = ALU_AND;
      endcase
    end else if (valid_w && inst_i[30]) begin
      alu_op_o = ALU_SUB;
    end
  end

  assign alu_word_o = valid_w || valid_iw;

  // register control
  assign raddr1_o  = inst_i[19:15];
  assign raddr2_o  = inst_i[24:20];
  assign rd_addr_o = inst_i[11:7];
  assign rd_we_o   = valid_r || valid_i || valid_w || valid_iw ||
                     opc_lui || opc_auipc || opc_jal || valid_jalr;

  // ====================
  // operand selection
  // ====================
  xlen_t imm;
  wire [4:0] imm_key = {opc_lui || opc_auipc, opc_jal, opc_i || opc_iw || opc_jalr,
                        opc_branch, opc_store};
  key_mux #(.NR_KEY(5)) u_imm_mux (
    .key_i     (imm_key),
    .default_i ('0),
    .data_i    ({imm_u, imm_j, imm_i, imm_b, imm_s}),
    .out_o     (imm)
  );

  // lui falls to the zero default for op1
  wire [1:0] op1_key = {opc_auipc || opc_jal || valid_jalr,
                        valid_r || valid_i || valid_w || valid_iw};
  key_mux #(.NR_KEY(2)) u_op1_mux (
    .key_i     (op1_key),
    .default_i ('0),
    .data_i    ({pc_i, rdata1_i}),
    .out_o     (op1_o)
  );

  // op2 of 4 builds the link address
  wire [2:0] op2_key = {valid_i || valid_iw || opc_lui || opc_auipc,
                        valid_r || valid_w, opc_jal || valid_jalr};
  key_mux #(.NR_KEY(3)) u_op2_mux (
    .key_i     (op2_key),
    .default_i ('0),
    .data_i    ({imm, rdata2_i, xlen_t'(4)}),
    .out_o     (op2_o)
  );

  // ====================
  // branch compare and target
  // ====================
  wire eq   = (rdata1_i == rdata2_i);
  wire lt_s = ($signed(rdata1_i) < $signed(rdata2_i));
  wire lt_u = (rdata1_i < rdata2_i);
  logic br_cond;

  always_comb begin
    case (funct3)
      `F3_BEQ:  br_cond = eq;
      `F3_BNE:  br_cond = !eq;
      `F3_BLT:  br_cond = lt_s;
      `F3_BGE:  br_cond = !lt_s;
      `F3_BLTU: br_cond = lt_u;
      `F3_BGEU: br_cond = !lt_u;
      default:  br_cond = 1'b0;
    endcase
  end

  assign taken_o = opc_jal || valid_jalr || (opc_branch && br_cond);
  assign halt_o  = is_ebreak;

  wire [1:0] tgt_key = {opc_jal || opc_branch, valid_jalr};
  key_mux #(.NR_KEY(2)) u_tgt_mux (
    .key_i     (tgt_key),
    .default_i ('0),
    .data_i    ({pc_i + imm, (rdata1_i + imm) & ~xlen_t'(1)}),
    .out_o     (target_o)
  );

endmodule

// ==== src/reg_file.sv ====
module reg_file (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                we_i,
  input  rv64_pkg::reg_addr_t waddr_i,
  input  rv64_pkg::xlen_t     wdata_i,
  input  rv64_pkg::reg_addr_t raddr1_i,
  input  rv64_pkg::reg_addr_t raddr2_i,
  output rv64_pkg::xlen_t     rdata1_o,
  output rv64_pkg::xlen_t     rdata2_o
);
  import rv64_pkg::*;

  xlen_t regs [0:31];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // asynchronous read ports
  assign rdata1_o = regs[raddr1_i];
  assign rdata2_o = regs[raddr2_i];

endmodule

// ==== src/exec_alu.sv ====
module exec_alu (
  input  rv64_pkg::xlen_t   op1_i,
  input  rv64_pkg::xlen_t   op2_i,
  input  rv64_pkg::alu_op_e alu_op_i,
  input  logic              word_i,
  output rv64_pkg::xlen_t   result_o
);
  import rv64_pkg::*;

  logic [5:0]  shamt;
  xlen_t       full;
  logic [31:0] low;

  assign shamt = op2_i[5:0];

  // ====================
  // 64-bit datapath
  // ====================
  always_comb begin
    case (alu_op_i)
      ALU_ADD:  full = op1_i + op2_i;
      ALU_SUB:  full = op1_i - op2_i;
      ALU_SLT:  full = xlen_t'($signed(op1_i) < $signed(op2_i));
      ALU_SLTU: full = xlen_t'(op1_i < op2_i);
      ALU_AND:  full = op1_i & op2_i;
      ALU_OR:   full = op1_i | op2_i;
      ALU_XOR:  full = op1_i ^ op2_i;
      ALU_SLL:  full = op1_i << shamt;
      ALU_SRL:  full = op1_i >> shamt;
      ALU_SRA:  full = xlen_t'($signed(op1_i) >>> shamt);
      default:  full = op1_i + op2_i;
    endcase
  end

  // word forms only use add and sub
  // the low word of the wide sum equals the 32-bit sum
  assign low = full[31:0];

  assign result_o = word_i ? {{32{low[31]}}, low} : full;

endmodule

// ==== src/fetch_ctrl.sv ====
`include "rv64_cfg.svh"

module fetch_ctrl (
  input  logic            clk,
  input  logic            reset_i,
  input  logic            wb_ack_i,
  input  rv64_pkg::inst_t wb_dat_i,
  input  logic            taken_i,
  input  rv64_pkg::xlen_t target_i,
  input  logic            halt_i,
  output logic            wb_cyc_o,
  output logic            wb_stb_o,
  output rv64_pkg::xlen_t wb_adr_o,
  output logic            wb_we_o,
  output rv64_pkg::xlen_t pc_o,
  output rv64_pkg::inst_t inst_o,
  output logic            exec_o,
  output logic            halted_o
);
  import rv64_pkg::*;

  typedef enum logic [1:0] {S_FETCH, S_EXEC, S_HALT} state_e;

  state_e state_q;
  logic   cyc_q;
  xlen_t  pc_q;
  inst_t  inst_q;

  // ====================
  // fetch and retire sequencing
  // ====================
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_FETCH;
      cyc_q   <= 1'b0;
      pc_q    <= `RESET_PC;
    end else begin
      case (state_q)
        S_FETCH: begin
          if (cyc_q && wb_ack_i) begin
            cyc_q   <= 1'b0;
            state_q <= S_EXEC;
          end else begin
            cyc_q <= 1'b1;
          end
        end
        S_EXEC: begin
          pc_q <= taken_i ? target_i : pc_q + xlen_t'(4);
          if (halt_i) begin
            state_q <= S_HALT;
          end else begin
            // next request goes out right away
            state_q <= S_FETCH;
            cyc_q   <= 1'b1;
          end
        end
        default: state_q <= S_HALT;
      endcase
    end
  end

  // instruction taken on the ack edge
  always_ff @(posedge clk) begin
    if (cyc_q && wb_ack_i) begin
      inst_q <= wb_dat_i;
    end
  end

  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = pc_q;
  assign wb_we_o  = 1'b0;
  assign pc_o     = pc_q;
  assign inst_o   = inst_q;
  assign exec_o   = (state_q == S_EXEC);
  assign halted_o = (state_q == S_HALT);

endmodule

// ==== src/rv64_core_lite.sv ====
module rv64_core_lite (
  input  logic                clk,
  input  logic                reset_i,
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output rv64_pkg::xlen_t     wb_adr_o,
  input  rv64_pkg::inst_t     wb_dat_i,
  input  logic                wb_ack_i,
  output logic                retire_o,
  output rv64_pkg::xlen_t     retire_pc_o,
  output logic                rd_we_o,
  output rv64_pkg::reg_addr_t rd_addr_o,
  output rv64_pkg::xlen_t     rd_data_o,
  output logic                halted_o
);
  import rv64_pkg::*;

  inst_t     inst;
  xlen_t     rdata1;
  xlen_t     rdata2;
  xlen_t     op1;
  xlen_t     op2;
  xlen_t     target;
  reg_addr_t raddr1;
  reg_addr_t raddr2;
  alu_op_e   alu_op;
  logic      alu_word;
  logic      taken;
  logic      halt;
  logic      dec_rd_we;

  // ====================
  // fetch and sequencing
  // ====================
  fetch_ctrl u_fetch (
    .clk      (clk),
    .reset_i  (reset_i),
    .wb_ack_i (wb_ack_i),
    .wb_dat_i (wb_dat_i),
    .taken_i  (taken),
    .target_i (target),
    .halt_i   (halt),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_adr_o (wb_adr_o),
    .wb_we_o  (wb_we_o),
    .pc_o     (retire_pc_o),
    .inst_o   (inst),
    .exec_o   (retire_o),
    .halted_o (halted_o)
  );

  inst_decode u_decode (
    .pc_i       (retire_pc_o),
    .inst_i     (inst),
    .rdata1_i   (rdata1),
    .rdata2_i   (rdata2),
    .raddr1_o   (raddr1),
    .raddr2_o   (raddr2),
    .rd_we_o    (dec_rd_we),
    .rd_addr_o  (rd_addr_o),
    .op1_o      (op1),
    .op2_o      (op2),
    .alu_op_o   (alu_op),
    .alu_word_o (alu_word),
    .taken_o    (taken),
    .target_o   (target),
    .halt_o     (halt)
  );

  // write only in the execute cycle
  assign rd_we_o = dec_rd_we & retire_o;

  reg_file u_regs (
    .clk      (clk),
    .reset_i  (reset_i),
    .we_i     (rd_we_o),
    .waddr_i  (rd_addr_o),
    .wdata_i  (rd_data_o),
    .raddr1_i (raddr1),
    .raddr2_i (raddr2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  exec_alu u_alu (
    .op1_i    (op1),
    .op2_i    (op2),
    .alu_op_i (alu_op),
    .word_i   (alu_word),
    .result_o (rd_data_o)
  );

endmodule

// ==== sim/tb_core.sv ====
`include "rv64_cfg.svh"

module tb_core;

  localparam int          CLK_PERIOD      = 40;
  localparam int          MEM_WORDS       = 128;
  localparam int          MAX_ACK_WAIT    = 3;
  localparam int          WATCHDOG_CYCLES = MEM_WORDS * (2 + MAX_ACK_WAIT + 2) + 100;
  localparam logic [31:0] SEED            = 32'h9875efcb;

  logic        clk;
  logic        reset_i;
  logic        wb_cyc_o;
  logic        wb_stb_o;
  logic        wb_we_o;
  logic [63:0] wb_adr_o;
  logic [31:0] wb_dat_i;
  logic        wb_ack_i;
  logic        retire_o;
  logic [63:0] retire_pc_o;
  logic        rd_we_o;
  logic [4:0]  rd_addr_o;
  logic [63:0] rd_data_o;
  logic        halted_o;

  logic [31:0] prog [0:MEM_WORDS-1];
  int          prog_len;
  int          ack_wait;
  int          errors;
  int          n_retired;
  logic [63:0] end_pc;
  logic        in_reset_q = 1'b0;

  // architectural model state
  logic [63:0] mregs [0:31];
  logic [63:0] mpc;
  logic        m_we;
  logic [4:0]  m_rd;
  logic [63:0] m_val;
  logic [63:0] m_next;
  logic        m_halt;

  rv64_core_lite uut (
    .clk         (clk),
    .reset_i     (reset_i),
    .wb_cyc_o    (wb_cyc_o),
    .wb_stb_o    (wb_stb_o),
    .wb_we_o     (wb_we_o),
    .wb_adr_o    (wb_adr_o),
    .wb_dat_i    (wb_dat_i),
    .wb_ack_i    (wb_ack_i),
    .retire_o    (retire_o),
    .retire_pc_o (retire_pc_o),
    .rd_we_o     (rd_we_o),
    .rd_addr_o   (rd_addr_o),
    .rd_data_o   (rd_data_o),
    .halted_o    (halted_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================
  // instruction encoders
  // ====================
  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd,
                                         input logic [6:0] opc);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] u_type(input int imm, input int rd, input logic [6:0] opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] j_type(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OPC_JAL};
  endfunction

  function automatic logic [31:0] b_type(input int off, input int rs2, input int rs1,
                                         input logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], `OPC_BRANCH};
  endfunction

  // counts in x31, only runs on a path that should be skipped or fallen into
  function automatic logic [31:0] skip_marker();
    return i_type(1, 31, `F3_ADD, 31, `OPC_OP_IMM);
  endfunction

  task automatic place_word(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic place_branch(input logic [2:0] f3, input int rs1, input int rs2);
    place_word(b_type(8, rs2, rs1, f3));
    place_word(skip_marker());
  endtask

  task automatic load_program();
    // unused words are addi x0 with the word index as immediate
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog[i] = i_type(i, 0, `F3_ADD, 0, `OPC_OP_IMM);
    end
    prog_len = 0;
    // operands and upper immediates
    place_word(u_type('h80000, 1, `OPC_LUI));
    place_word(i_type(-5, 0, `F3_ADD, 2, `OPC_OP_IMM));
    place_word(i_type(7, 0, `F3_ADD, 3, `OPC_OP_IMM));
    place_word(u_type('h12345, 4, `OPC_AUIPC));
    // register-register, shift amount 40
    place_word(r_type(`F7_BASE, 2, 1, `F3_ADD, 5, `OPC_OP));
    place_word(r_type(`F7_ALT, 2, 3, `F3_ADD, 6, `OPC_OP));
    place_word(r_type(`F7_BASE, 3, 2, `F3_SLT, 7, `OPC_OP));
    place_word(r_type(`F7_BASE, 3, 2, `F3_SLTU, 8, `OPC_OP));
    place_word(r_type(`F7_BASE, 2, 1, `F3_AND, 9, `OPC_OP));
    place_word(r_type(`F7_BASE, 3, 2, `F3_OR, 10, `OPC_OP));
    place_word(r_type(`F7_BASE, 3, 1, `F3_XOR, 11, `OPC_OP));
    place_word(i_type(40, 0, `F3_ADD, 12, `OPC_OP_IMM));
    place_word(r_type(`F7_BASE, 12, 3, `F3_SLL, 13, `OPC_OP));
    place_word(r_type(`F7_BASE, 12, 2, `F3_SRL, 14, `OPC_OP));
    place_word(r_type(`F7_ALT, 12, 2, `F3_SRL, 15, `OPC_OP));
    // immediate forms
    place_word(i_type(-3, 2, `F3_SLT, 16, `OPC_OP_IMM));
    place_word(i_type(-1, 3, `F3_SLTU, 17, `OPC_OP_IMM));
    place_word(i_type('h0f0, 2, `F3_AND, 18, `OPC_OP_IMM));
    place_word(i_type(-256, 1, `F3_OR, 19, `OPC_OP_IMM));
    place_word(i_type('h555, 2, `F3_XOR, 20, `OPC_OP_IMM));
    place_word(i_type(35, 3, `F3_SLL, 21, `OPC_OP_IMM));
    place_word(i_type(33, 2, `F3_SRL, 22, `OPC_OP_IMM));
    place_word(i_type('h400 + 40, 1, `F3_SRL, 23, `OPC_OP_IMM));
    // word forms
    place_word(u_type('h7ffff, 25, `OPC_LUI));
    place_word(r_type(`F7_BASE, 25, 25, `F3_ADD, 26, `OPC_OP_32));
    place_word(r_type(`F7_ALT, 3, 1, `F3_ADD, 27, `OPC_OP_32));
    place_word(i_type(-1, 1, `F3_ADD, 28, `OPC_OP_IMM_32));
    place_word(i_type(0, 2, `F3_ADD, 29, `OPC_OP_IMM_32));
    // write to x0, then read it back
    place_word(i_type(99, 3, `F3_ADD, 0, `OPC_OP_IMM));
    place_word(r_type(`F7_BASE, 3, 0, `F3_ADD, 30, `OPC_OP));
    // branches, x2 is -5 and x3 is 7
    place_branch(`F3_BEQ, 3, 3);
    place_branch(`F3_BEQ, 2, 3);
    place_branch(`F3_BNE, 2, 3);
    place_branch(`F3_BNE, 0, 0);
    place_branch(`F3_BLT, 2, 3);
    place_branch(`F3_BLT, 3, 2);
    place_branch(`F3_BGE, 3, 2);
    place_branch(`F3_BGE, 2, 3);
    place_branch(`F3_BLTU, 3, 2);
    place_branch(`F3_BLTU, 2, 3);
    place_branch(`F3_BGEU, 2, 3);
    place_branch(`F3_BGEU, 3, 2);
    // small backward loop
    place_word(i_type(3, 0, `F3_ADD, 30, `OPC_OP_IMM));
    place_word(i_type(-1, 30, `F3_ADD, 30, `OPC_OP_IMM));
    place_word(b_type(-4, 0, 30, `F3_BNE));
    // jal over two words, then jalr to an odd sum
    place_word(j_type(12, 1));
    place_word(skip_marker());
    place_word(skip_marker());
    place_word(u_type(0, 5, `OPC_AUIPC));
    place_word(i_type(14, 5, `F3_ADD, 5, `OPC_OP_IMM));
    place_word(i_type(3, 5, `F3_JALR, 6, `OPC_JALR));
    place_word(skip_marker());
    end_pc = 64'(prog_len) * 64'd4 + 64'd4;
    place_word(`INST_EBREAK);
  endtask

  // ====================
  // wishbone slave
  // ====================
  always @(posedge clk) begin
    #2;
    if (reset_i || !wb_cyc_o || !wb_stb_o) begin
      wb_ack_i = 1'b0;
      ack_wait = int'($urandom % (MAX_ACK_WAIT + 1));
    end else if (ack_wait == 0) begin
      wb_ack_i = 1'b1;
      wb_dat_i = prog[wb_adr_o[8:2]];
    end else begin
      wb_ack_i = 1'b0;
      ack_wait--;
    end
  end

  // ====================
  // reference model
  // ====================
  function automatic logic [63:0] int_op_result(input logic [2:0] f3, input logic alt,
                                                input logic [63:0] x, input logic [63:0] y);
    logic [5:0] sh;
    sh = y[5:0];
    case (f3)
      `F3_ADD:  return alt ? x - y : x + y;
      `F3_SLL:  return x << sh;
      `F3_SLT:  return {63'd0, $signed(x) < $signed(y)};
      `F3_SLTU: return {63'd0, x < y};
      `F3_XOR:  return x ^ y;
      `F3_SRL: begin
        if (alt) begin
          return $signed(x) >>> sh;
        end
        return x >> sh;
      end
      `F3_OR:   return x | y;
      default:  return x & y;
    endcase
  endfunction

  function automatic logic [63:0] widen_word(input logic [31:0] w);
    return 64'($signed(w));
  endfunction

  always_comb begin : ref_model
    logic [31:0] ins;
    logic [63:0] src1;
    logic [63:0] src2;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    logic [63:0] imm_b;
    logic [63:0] imm_j;
    logic        cond;
    ins    = prog[mpc[8:2]];
    src1   = mregs[ins[19:15]];
    src2   = mregs[ins[24:20]];
    imm_i  = 64'($signed(ins[31:20]));
    imm_u  = 64'($signed({ins[31:12], 12'h000}));
    imm_b  = 64'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
    imm_j  = 64'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
    cond   = 1'b0;
    m_we   = 1'b0;
    m_rd   = ins[11:7];
    m_val  = '0;
    m_next = mpc + 64'd4;
    m_halt = 1'b0;
    case (ins[6:0])
      `OPC_OP: begin
        m_we  = 1'b1;
        m_val = int_op_result(ins[14:12], ins[30], src1, src2);
      end
      `OPC_OP_IMM: begin
        m_we  = 1'b1;
        m_val = int_op_result(ins[14:12], ins[30] && (ins[14:12] == `F3_SRL), src1, imm_i);
      end
      `OPC_OP_32: begin
        m_we  = 1'b1;
        m_val = ins[30] ? widen_word(src1[31:0] - src2[31:0])
                        : widen_word(src1[31:0] + src2[31:0]);
      end
      `OPC_OP_IMM_32: begin
        m_we  = 1'b1;
        m_val = widen_word(src1[31:0] + imm_i[31:0]);
      end
      `OPC_LUI: begin
        m_we  = 1'b1;
        m_val = imm_u;
      end
      `OPC_AUIPC: begin
        m_we  = 1'b1;
        m_val = mpc + imm_u;
      end
      `OPC_JAL: begin
        m_we   = 1'b1;
        m_val  = mpc + 64'd4;
        m_next = mpc + imm_j;
      end
      `OPC_JALR: begin
        m_we   = 1'b1;
        m_val  = mpc + 64'd4;
        m_next = (src1 + imm_i) & ~64'd1;
      end
      `OPC_BRANCH: begin
        case (ins[14:12])
          `F3_BEQ:  cond = (src1 == src2);
          `F3_BNE:  cond = (src1 != src2);
          `F3_BLT:  cond = ($signed(src1) < $signed(src2));
          `F3_BGE:  cond = ($signed(src1) >= $signed(src2));
          `F3_BLTU: cond = (src1 < src2);
          `F3_BGEU: cond = (src1 >= src2);
          default:  cond = 1'b0;
        endcase
        if (cond) begin
          m_next = mpc + imm_b;
        end
      end
      default: m_halt = (ins == `INST_EBREAK);
    endcase
  end

  // model steps once per retire
  always @(posedge clk) begin
    in_reset_q <= reset_i;
    if (reset_i) begin
      for (int r = 0; r < 32; r++) begin
        mregs[r] <= '0;
      end
      mpc <= `RESET_PC;
    end else if (retire_o) begin
      if (m_we && (m_rd != 5'd0)) begin
        mregs[m_rd] <= m_val;
      end
      mpc       <= m_next;
      n_retired <= n_retired + 1;
    end
  end

  // ====================
  // checks
  // ====================
  a_reset_quiet: assert property (@(posedge clk)
    reset_i && in_reset_q |-> !wb_cyc_o && !wb_stb_o && !retire_o && !halted_o)
  else begin
    errors++;
    $display("%0t: bus or retire outputs active during reset", $time);
  end

  a_first_fetch: assert property (@(posedge clk)
    $past(reset_i, 2) && !$past(reset_i) |-> wb_cyc_o && wb_stb_o && wb_adr_o == `RESET_PC)
  else begin
    errors++;
    $display("%0t: first fetch after reset missing or not at the reset address", $time);
  end

  // request holds steady until the slave acks
  a_req_hold: assert property (@(posedge clk) disable iff (reset_i)
    $past(wb_cyc_o && !wb_ack_i) |-> wb_cyc_o && wb_stb_o && !wb_we_o && $stable(wb_adr_o))
  else begin
    errors++;
    $display("%0t: wishbone request dropped or changed before ack", $time);
  end

  a_retire_after_ack: assert property (@(posedge clk) disable iff (reset_i)
    retire_o == $past(wb_cyc_o && wb_ack_i))
  else begin
    errors++;
    $display("%0t: retire pulse not exactly one cycle after ack", $time);
  end

  a_retire_pc: assert property (@(posedge clk) disable iff (reset_i)
    retire_o |-> retire_pc_o == mpc)
  else begin
    errors++;
    $display("ERROR %0t retire_pc_o: got %h, expected %h", $time,
             $sampled(retire_pc_o), $sampled(mpc));
  end

  a_rd_we: assert property (@(posedge clk) disable iff (reset_i)
    rd_we_o == (retire_o && m_we))
  else begin
    errors++;
    $display("ERROR %0t rd_we_o: got %b, expected %b", $time,
             $sampled(rd_we_o), $sampled(retire_o && m_we));
  end

  a_rd_addr: assert property (@(posedge clk) disable iff (reset_i)
    retire_o && m_we |-> rd_addr_o == m_rd)
  else begin
    errors++;
    $display("ERROR %0t rd_addr_o: got %0d, expected %0d", $time,
             $sampled(rd_addr_o), $sampled(m_rd));
  end

  a_rd_data: assert property (@(posedge clk) disable iff (reset_i)
    retire_o && m_we |-> rd_data_o == m_val)
  else begin
    errors++;
    $display("ERROR %0t rd_data_o: got %h, expected %h", $time,
             $sampled(rd_data_o), $sampled(m_val));
  end

  // halted rises only right after ebreak retires
  a_halt_rise: assert property (@(posedge clk) disable iff (reset_i)
    (halted_o && !$past(halted_o)) == $past(retire_o && m_halt))
  else begin
    errors++;
    $display("%0t: halted_o did not follow the ebreak retire", $time);
  end

  a_halt_hold: assert property (@(posedge clk) disable iff (reset_i)
    $past(halted_o) |-> halted_o && !wb_cyc_o)
  else begin
    errors++;
    $display("%0t: core left halt or fetched while halted", $time);
  end

  // ====================
  // main sequence and watchdog
  // ====================
  initial begin
    clk       = 1'b0;
    reset_i   = 1'b1;
    wb_ack_i  = 1'b0;
    wb_dat_i  = '0;
    errors    = 0;
    n_retired = 0;
    ack_wait  = 0;
    void'($urandom(SEED));
    load_program();
    repeat (5) @(posedge clk);
    #2 reset_i = 1'b0;
    wait (halted_o === 1'b1);
    // stay halted, no fetch
    repeat (20) @(posedge clk);
    #2;
    if (mpc != end_pc) begin
      errors++;
      $display("model did not step through the program up to the final ebreak");
    end
    $display("errors: %0d, instructions retired: %0d", errors, n_retired);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles without the core halting", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+include
src/rv64_pkg.sv
src/key_mux.sv
src/inst_decode.sv
src/reg_file.sv
src/exec_alu.sv
src/fetch_ctrl.sv
src/rv64_core_lite.sv
sim/tb_core.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := tb_core
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only if the simulation printed the pass line
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
